//--- Makefile
# Verilator build for the systolic array testbench
# override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_systolic_array
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_STR  ?= sim passed

SRCS := $(shell cat $(FILELIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(EXE)
	./$(EXE) | tee $(LOG)
	grep -q "^$(PASS_STR)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
verilog/sa_cfg_pkg.sv
verilog/sa_ctrl_pkg.sv
verilog/systolic_pe.sv
verilog/pe_grid.sv
verilog/weight_loader.sv
verilog/act_feeder.sv
verilog/psum_accum.sv
verilog/systolic_array_top.sv
verification/tb_clkgen.sv
verification/tb_systolic_array.sv

//--- verification/tb_clkgen.sv
// ---------------------------------------------------------------------------
// Free-running clock and active-high reset for the testbench.
// Reset is released on a rising edge after RST_CYCLES full cycles.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 10
) (
    output logic o_clk,
    output logic o_rst
);
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

//--- verification/tb_systolic_array.sv
// ---------------------------------------------------------------------------
// Testbench for the systolic multiplier with the default TILE_ROWS of 4.
// Tiles come from a table filled with seeded random rows. Expected rows
// follow a signed model that restarts its sums on every init tile.
// Results are read only between tiles, after o_done.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_systolic_array;
    import sa_cfg_pkg::*;
    import sa_ctrl_pkg::*;

    localparam int TILE_ROWS  = 4;
    localparam int ROW_W      = $clog2(TILE_ROWS);
    localparam int NUM_TILES  = 6;
    localparam int BEAT_LIMIT = 200;
    localparam int DONE_LIMIT = 200;

    logic             s_clk;
    logic             s_rst;
    logic             init;
    slice_beat_t      b_slice;
    slice_beat_t      a_slice;
    logic             o_b_ready;
    logic             o_a_ready;
    logic             o_done;
    logic [ROW_W-1:0] rd_row;
    psum_row_t        o_rd_data;

    // stimulus table with one entry per tile
    data_row_t a_tab   [NUM_TILES][TILE_ROWS];
    data_row_t b_tab   [NUM_TILES][ARRAY_N];
    psum_row_t exp_tab [NUM_TILES][TILE_ROWS];
    logic      init_tab [NUM_TILES] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
    // B of the next tile follows straight after this one
    logic      queue_b  [NUM_TILES] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
    logic      b_sent   [NUM_TILES] = '{default: 1'b0};

    int   mismatches = 0;
    int   timeouts   = 0;
    logic timed_out  = 1'b0;

    tb_clkgen #(.PERIOD_NS(40), .RST_CYCLES(10)) u_clkgen (.o_clk(s_clk), .o_rst(s_rst));

    systolic_array_top #(.TILE_ROWS(TILE_ROWS)) dut0 (
        .s_clk     (s_clk),
        .s_rst     (s_rst),
        .i_init    (init),
        .i_b_slice (b_slice),
        .o_b_ready (o_b_ready),
        .i_a_slice (a_slice),
        .o_a_ready (o_a_ready),
        .o_done    (o_done),
        .i_rd_row  (rd_row),
        .o_rd_data (o_rd_data)
    );

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    function automatic logic sig_value(input string name);
        case (name)
            "o_b_ready": sig_value = o_b_ready;
            "o_a_ready": sig_value = o_a_ready;
            default:     sig_value = o_done;
        endcase
    endfunction

    task automatic wait_high(input string name, input int limit);
        int n;
        n = 0;
        @(negedge s_clk);
        while (!sig_value(name) && n < limit) begin
            @(negedge s_clk);
            n++;
        end
        if (!sig_value(name)) begin
            timeouts++;
            timed_out = 1'b1;
            $display("timeout: %s stayed low for %0d cycles", name, limit);
        end
    endtask

    task automatic build_table();
        int acc [TILE_ROWS][ARRAY_N];
        int dot;
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int k = 0; k < ARRAY_N; k++) begin
                for (int i = 0; i < TILE_ROWS; i++)
                    a_tab[t][i][k] = DATA_W'($urandom);
                for (int c = 0; c < ARRAY_N; c++)
                    b_tab[t][k][c] = (t == 0) ? DATA_W'(k == c) : DATA_W'($urandom);
            end
        end
        // identity tile also carries the most negative element
        a_tab[0][0][0] = 8'h80;
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int i = 0; i < TILE_ROWS; i++) begin
                for (int c = 0; c < ARRAY_N; c++) begin
                    if (init_tab[t])
                        acc[i][c] = 0;
                    dot = 0;
                    for (int k = 0; k < ARRAY_N; k++)
                        dot += $signed(a_tab[t][i][k]) * $signed(b_tab[t][k][c]);
                    acc[i][c] += dot;
                    exp_tab[t][i][c] = PSUM_W'(acc[i][c]);
                end
            end
        end
    endtask

    task automatic pulse_init();
        @(posedge s_clk);
        init <= 1'b1;
        @(posedge s_clk);
        init <= 1'b0;
    endtask

    // each beat is held until ready
    task automatic send_rows(input logic to_a, input int t);
        slice_beat_t beat;
        int          n;
        n = to_a ? TILE_ROWS : ARRAY_N;
        @(posedge s_clk);
        for (int k = 0; k < n; k++) begin
            beat.valid = 1'b1;
            beat.last  = (k == n - 1);
            beat.data  = to_a ? a_tab[t][k] : b_tab[t][k];
            if (to_a)
                a_slice <= beat;
            else
                b_slice <= beat;
            wait_high(to_a ? "o_a_ready" : "o_b_ready", BEAT_LIMIT);
            if (timed_out)
                break;
            @(posedge s_clk);
        end
        a_slice <= '0;
        b_slice <= '0;
    endtask

    task automatic read_check(input int t);
        psum_row_t got;
        for (int i = 0; i < TILE_ROWS; i++) begin
            @(posedge s_clk);
            rd_row <= ROW_W'(i);
            @(posedge s_clk);
            @(negedge s_clk);
            got = o_rd_data;
            for (int c = 0; c < ARRAY_N; c++)
                check_val($sformatf("o_rd_data tile %0d row %0d col %0d", t, i, c),
                          32'(got[c]), 32'(exp_tab[t][i][c]));
        end
    endtask

    initial begin
        int seed;
        int n;
        init    = 1'b0;
        b_slice = '0;
        a_slice = '0;
        rd_row  = '0;
        seed    = $urandom(52879);
        build_table();

        @(posedge s_clk);
        n = 0;
        while (s_rst && n < 50) begin
            @(negedge s_clk);
            n++;
        end
        if (s_rst) begin
            timeouts++;
            timed_out = 1'b1;
            $display("timeout: reset was never released");
        end
        check_val("o_done", 32'(o_done), 32'h0);
        wait_high("o_b_ready", 4);
        wait_high("o_a_ready", 4);

        for (int t = 0; t < NUM_TILES && !timed_out; t++) begin
            if (init_tab[t])
                pulse_init();
            if (!b_sent[t])
                send_rows(1'b0, t);
            if (queue_b[t]) begin
                send_rows(1'b0, t + 1);
                b_sent[t+1] = 1'b1;
                // both weight banks hold pending tiles now
                repeat (3) @(posedge s_clk);
                @(negedge s_clk);
                check_val("o_b_ready", 32'(o_b_ready), 32'h0);
            end
            send_rows(1'b1, t);
            if (!timed_out)
                wait_high("o_done", DONE_LIMIT);
            if (!timed_out) begin
                @(negedge s_clk);
                check_val("o_done", 32'(o_done), 32'h0);
                read_check(t);
            end
        end

        $display("closing report: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- verilog/act_feeder.sv
// ---------------------------------------------------------------------------
// A slice intake into two activation banks of TILE_ROWS rows, plus the
// compute sequencer. A tile starts once both an activation bank and a
// weight bank are complete. Grid row r sees element r of A row i at step
// i + r. The tile ends when the accumulator reports all columns written.
// i_init is only legal while the sequencer is idle.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module act_feeder #(
    parameter int TILE_ROWS = 4
) (
    input  logic                           s_clk,
    input  logic                           s_rst,
    input  logic                           i_init,
    input  sa_ctrl_pkg::slice_beat_t       i_a_slice,
    output logic                           o_a_ready,
    input  logic                           i_w_avail,
    input  logic                           i_accum_done,
    output logic                           o_tile_done,
    output sa_cfg_pkg::data_row_t          o_act_col,
    output logic [sa_cfg_pkg::ARRAY_N-1:0] o_act_valid,
    output logic                           o_first_tile
);
    import sa_cfg_pkg::*;
    import sa_ctrl_pkg::*;

    localparam int ROW_W     = $clog2(TILE_ROWS);
    localparam int LAST_STEP = TILE_ROWS + ARRAY_N - 2;
    localparam int STEP_W    = $clog2(LAST_STEP + 1);

    data_row_t         act_mem [2][TILE_ROWS];
    logic [1:0]        load_ptr;
    logic [1:0]        calc_ptr;
    logic              bank_full;
    logic              bank_empty;
    logic              accept;
    logic              last_d;
    logic [ROW_W-1:0]  wr_cnt;
    seq_state_e        state;
    logic [STEP_W-1:0] step;

    assign accept      = o_a_ready && i_a_slice.valid;
    assign bank_empty  = load_ptr == calc_ptr;
    assign bank_full   = (load_ptr[1] ^ calc_ptr[1]) && (load_ptr[0] == calc_ptr[0]);
    assign o_tile_done = (state == SEQ_DRAIN) && i_accum_done;

    always_ff @(posedge s_clk) begin
        if (accept)
            act_mem[load_ptr[0]][wr_cnt] <= i_a_slice.data;
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_a_ready    <= 1'b0;
            last_d       <= 1'b0;
            load_ptr     <= 2'd0;
            calc_ptr     <= 2'd0;
            wr_cnt       <= '0;
            o_first_tile <= 1'b1;
        end else begin
            last_d <= accept && i_a_slice.last;
            if (accept && i_a_slice.last)
                o_a_ready <= 1'b0;
            else
                o_a_ready <= !bank_full && !last_d;
            if (last_d)
                load_ptr <= load_ptr + 2'd1;
            if (o_tile_done)
                calc_ptr <= calc_ptr + 2'd1;
            if (accept)
                wr_cnt <= i_a_slice.last ? '0 : wr_cnt + 1'b1;
            if (i_init)
                o_first_tile <= 1'b1;
            else if (o_tile_done)
                o_first_tile <= 1'b0;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state <= SEQ_IDLE;
            step  <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    step <= '0;
                    if (!bank_empty && i_w_avail)
                        state <= SEQ_FEED;
                end
                SEQ_FEED: begin
                    if (step == STEP_W'(LAST_STEP))
                        state <= SEQ_DRAIN;
                    else
                        step <= step + 1'b1;
                end
                SEQ_DRAIN: begin
                    if (i_accum_done)
                        state <= SEQ_IDLE;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // diagonal skew, row r lags row 0 by r steps
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_act_valid <= '0;
        end else begin
            for (int r = 0; r < ARRAY_N; r++) begin
                o_act_valid[r] <= (state == SEQ_FEED) && (int'(step) >= r)
                                  && (int'(step) < r + TILE_ROWS);
            end
        end
    end

    always_ff @(posedge s_clk) begin
        for (int r = 0; r < ARRAY_N; r++) begin
            o_act_col[r] <= act_mem[calc_ptr[0]][ROW_W'(int'(step) - r)][r];
        end
    end

    a_init_idle: assert property (@(posedge s_clk) disable iff (s_rst)
        i_init |-> state == SEQ_IDLE);

endmodule

//--- verilog/pe_grid.sv
// ---------------------------------------------------------------------------
// Square grid of processing elements. PE row r holds weight row r of B.
// Activation element r enters grid row r from the left and the partial
// sums run down the columns from zero. Inputs must arrive skewed by one
// cycle per row, and column c comes out c cycles after column 0.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module pe_grid (
    input  logic                           s_clk,
    input  logic                           s_rst,
    input  sa_ctrl_pkg::grid_ctrl_t        i_grid_ctrl,
    input  sa_cfg_pkg::data_row_t          i_w_row,
    input  sa_cfg_pkg::data_row_t          i_act_col,
    input  logic [sa_cfg_pkg::ARRAY_N-1:0] i_act_valid,
    output sa_cfg_pkg::psum_row_t          o_psum_row,
    output logic [sa_cfg_pkg::ARRAY_N-1:0] o_psum_valid
);
    import sa_cfg_pkg::*;

    logic [DATA_W-1:0] act_w  [ARRAY_N][ARRAY_N+1];
    logic              act_v  [ARRAY_N][ARRAY_N+1];
    logic [PSUM_W-1:0] psum_w [ARRAY_N+1][ARRAY_N];
    logic              psum_v [ARRAY_N][ARRAY_N];

    genvar r, c;
    generate
        for (r = 0; r < ARRAY_N; r++) begin : g_row
            logic [1:0] w_load;

            assign w_load = {i_grid_ctrl.row_wr[r] &  i_grid_ctrl.load_bank,
                             i_grid_ctrl.row_wr[r] & ~i_grid_ctrl.load_bank};
            assign act_w[r][0] = i_act_col[r];
            assign act_v[r][0] = i_act_valid[r];

            for (c = 0; c < ARRAY_N; c++) begin : g_col
                systolic_pe u_pe (
                    .s_clk        (s_clk),
                    .s_rst        (s_rst),
                    .i_w_load     (w_load),
                    .i_w_sel      (i_grid_ctrl.calc_bank),
                    .i_weight     (i_w_row[c]),
                    .i_act        (act_w[r][c]),
                    .i_act_valid  (act_v[r][c]),
                    .i_psum       (psum_w[r][c]),
                    .o_act        (act_w[r][c+1]),
                    .o_act_valid  (act_v[r][c+1]),
                    .o_psum       (psum_w[r+1][c]),
                    .o_psum_valid (psum_v[r][c])
                );
            end
        end

        // zero at the top edge, results at the bottom edge
        for (c = 0; c < ARRAY_N; c++) begin : g_edge
            assign psum_w[0][c]    = '0;
            assign o_psum_row[c]   = psum_w[ARRAY_N][c];
            assign o_psum_valid[c] = psum_v[ARRAY_N-1][c];
        end
    endgenerate

endmodule

//--- verilog/psum_accum.sv
// ---------------------------------------------------------------------------
// Collects the skewed column outputs into a TILE_ROWS deep result store.
// The first tile overwrites and later tiles add, wrapping at PSUM_W bits.
// Read data is registered and follows i_rd_row by one cycle.
// Reading during a tile returns a mix of old and new values.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module psum_accum #(
    parameter int TILE_ROWS = 4
) (
    input  logic                           s_clk,
    input  logic                           s_rst,
    input  logic                           i_first_tile,
    input  sa_cfg_pkg::psum_row_t          i_psum_row,
    input  logic [sa_cfg_pkg::ARRAY_N-1:0] i_psum_valid,
    output logic                           o_accum_done,
    input  logic [$clog2(TILE_ROWS)-1:0]   i_rd_row,
    output sa_cfg_pkg::psum_row_t          o_rd_data
);
    import sa_cfg_pkg::*;

    localparam int ROW_W = $clog2(TILE_ROWS);

    psum_row_t          store [TILE_ROWS];
    logic [ROW_W-1:0]   col_row [ARRAY_N];
    logic [ARRAY_N-1:0] col_done;

    // each column walks its own row index
    always_ff @(posedge s_clk) begin
        for (int c = 0; c < ARRAY_N; c++) begin
            if (i_psum_valid[c]) begin
                if (i_first_tile)
                    store[col_row[c]][c] <= i_psum_row[c];
                else
                    store[col_row[c]][c] <= store[col_row[c]][c] + i_psum_row[c];
            end
        end
        o_rd_data <= store[i_rd_row];
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            col_done <= '0;
            for (int c = 0; c < ARRAY_N; c++) begin
                col_row[c] <= '0;
            end
        end else if (o_accum_done) begin
            col_done <= '0;
        end else begin
            for (int c = 0; c < ARRAY_N; c++) begin
                if (i_psum_valid[c]) begin
                    if (col_row[c] == ROW_W'(TILE_ROWS - 1)) begin
                        col_row[c]  <= '0;
                        col_done[c] <= 1'b1;
                    end else begin
                        col_row[c] <= col_row[c] + 1'b1;
                    end
                end
            end
        end
    end

    // high for one cycle once the last column has landed
    assign o_accum_done = &col_done;

    // the feeder must never issue more than TILE_ROWS rows per tile
    a_no_extra_rows: assert property (@(posedge s_clk) disable iff (s_rst)
        (i_psum_valid & col_done) == '0);

endmodule

//--- verilog/sa_cfg_pkg.sv
// ---------------------------------------------------------------------------
// Array geometry and arithmetic widths shared by every block.
// Partial sums wrap silently at PSUM_W bits. A dot product of ARRAY_N
// signed 8-bit pairs needs 18 bits, so about a hundred tiles can be
// accumulated before an overflow is possible.
// ---------------------------------------------------------------------------
package sa_cfg_pkg;

    localparam int ARRAY_N = 4;
    localparam int DATA_W  = 8;
    localparam int PSUM_W  = 24;

    // one matrix row with element 0 in the low bits
    typedef logic [ARRAY_N-1:0][DATA_W-1:0] data_row_t;

    // one result row with column 0 in the low bits
    typedef logic [ARRAY_N-1:0][PSUM_W-1:0] psum_row_t;

endpackage

//--- verilog/sa_ctrl_pkg.sv
// ---------------------------------------------------------------------------
// Control types for the slice streams, the grid and the sequencer.
// A beat is one full matrix row. The last flag marks the final row of a
// tile and must be set on exactly one beat per tile.
// ---------------------------------------------------------------------------
package sa_ctrl_pkg;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_FEED,
        SEQ_DRAIN
    } seq_state_e;

    // input stream beat, ready travels separately
    typedef struct packed {
        logic                  valid;
        logic                  last;
        sa_cfg_pkg::data_row_t data;
    } slice_beat_t;

    // weight bank selects and one-hot row write strobe
    typedef struct packed {
        logic                           load_bank;
        logic                           calc_bank;
        logic [sa_cfg_pkg::ARRAY_N-1:0] row_wr;
    } grid_ctrl_t;

endpackage

//--- verilog/systolic_array_top.sv
// ---------------------------------------------------------------------------
// Weight-stationary systolic multiplier, C += A x B per tile.
// B arrives as ARRAY_N row beats and A as TILE_ROWS row beats, each with
// last on the final beat. Both streams hold two tiles. o_done pulses once
// the result store is updated. Raise i_init only between tiles.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module systolic_array_top #(
    parameter int TILE_ROWS = 4
) (
    input  logic                         s_clk,
    input  logic                         s_rst,
    input  logic                         i_init,
    input  sa_ctrl_pkg::slice_beat_t     i_b_slice,
    output logic                         o_b_ready,
    input  sa_ctrl_pkg::slice_beat_t     i_a_slice,
    output logic                         o_a_ready,
    output logic                         o_done,
    input  logic [$clog2(TILE_ROWS)-1:0] i_rd_row,
    output sa_cfg_pkg::psum_row_t        o_rd_data
);
    import sa_cfg_pkg::*;
    import sa_ctrl_pkg::*;

    grid_ctrl_t         grid_ctrl;
    data_row_t          w_row;
    logic               w_avail;
    data_row_t          act_col;
    logic [ARRAY_N-1:0] act_valid;
    logic               first_tile;
    psum_row_t          psum_row;
    logic [ARRAY_N-1:0] psum_valid;
    logic               accum_done;

    weight_loader u_weight_loader (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_b_slice   (i_b_slice),
        .o_b_ready   (o_b_ready),
        .i_tile_done (o_done),
        .o_grid_ctrl (grid_ctrl),
        .o_w_row     (w_row),
        .o_w_avail   (w_avail)
    );

    act_feeder #(
        .TILE_ROWS (TILE_ROWS)
    ) u_act_feeder (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_init       (i_init),
        .i_a_slice    (i_a_slice),
        .o_a_ready    (o_a_ready),
        .i_w_avail    (w_avail),
        .i_accum_done (accum_done),
        .o_tile_done  (o_done),
        .o_act_col    (act_col),
        .o_act_valid  (act_valid),
        .o_first_tile (first_tile)
    );

    pe_grid u_pe_grid (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_grid_ctrl  (grid_ctrl),
        .i_w_row      (w_row),
        .i_act_col    (act_col),
        .i_act_valid  (act_valid),
        .o_psum_row   (psum_row),
        .o_psum_valid (psum_valid)
    );

    psum_accum #(
        .TILE_ROWS (TILE_ROWS)
    ) u_psum_accum (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_first_tile (first_tile),
        .i_psum_row   (psum_row),
        .i_psum_valid (psum_valid),
        .o_accum_done (accum_done),
        .i_rd_row     (i_rd_row),
        .o_rd_data    (o_rd_data)
    );

endmodule

//--- verilog/systolic_pe.sv
// ---------------------------------------------------------------------------
// Weight-stationary processing element with two weight banks.
// The activation and the partial sum are both registered, so a PE adds
// one cycle of latency in each direction.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module systolic_pe (
    input  logic                                 s_clk,
    input  logic                                 s_rst,
    input  logic [1:0]                           i_w_load,
    input  logic                                 i_w_sel,
    input  logic signed [sa_cfg_pkg::DATA_W-1:0] i_weight,
    input  logic signed [sa_cfg_pkg::DATA_W-1:0] i_act,
    input  logic                                 i_act_valid,
    input  logic [sa_cfg_pkg::PSUM_W-1:0]        i_psum,
    output logic signed [sa_cfg_pkg::DATA_W-1:0] o_act,
    output logic                                 o_act_valid,
    output logic [sa_cfg_pkg::PSUM_W-1:0]        o_psum,
    output logic                                 o_psum_valid
);
    import sa_cfg_pkg::*;

    logic signed [DATA_W-1:0]   weight_q [2];
    logic signed [2*DATA_W-1:0] prod;
    logic                       valid_q;

    // one bank loads while the other computes
    always_ff @(posedge s_clk) begin
        for (int b = 0; b < 2; b++) begin
            if (i_w_load[b])
                weight_q[b] <= i_weight;
        end
    end

    assign prod = i_act * weight_q[i_w_sel];

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst)
            valid_q <= 1'b0;
        else
            valid_q <= i_act_valid;
    end

    always_ff @(posedge s_clk) begin
        o_act  <= i_act;
        o_psum <= i_psum + {{(PSUM_W-2*DATA_W){prod[2*DATA_W-1]}}, prod};
    end

    assign o_act_valid  = valid_q;
    assign o_psum_valid = valid_q;

endmodule

//--- verilog/weight_loader.sv
// ---------------------------------------------------------------------------
// B slice intake into two weight banks inside the grid. Exactly ARRAY_N
// beats form a tile. Beat k writes grid row k directly from the stream,
// so the producer must hold data stable until it is taken. Ready drops
// for two cycles after each last beat while the bank pointer moves.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module weight_loader (
    input  logic                     s_clk,
    input  logic                     s_rst,
    input  sa_ctrl_pkg::slice_beat_t i_b_slice,
    output logic                     o_b_ready,
    input  logic                     i_tile_done,
    output sa_ctrl_pkg::grid_ctrl_t  o_grid_ctrl,
    output sa_cfg_pkg::data_row_t    o_w_row,
    output logic                     o_w_avail
);
    import sa_cfg_pkg::*;

    localparam int CNT_W = $clog2(ARRAY_N);

    logic [1:0]       load_ptr;
    logic [1:0]       calc_ptr;
    logic             bank_full;
    logic             bank_empty;
    logic             accept;
    logic             last_d;
    logic [CNT_W-1:0] row_cnt;

    assign accept     = o_b_ready && i_b_slice.valid;
    assign bank_empty = load_ptr == calc_ptr;
    assign bank_full  = (load_ptr[1] ^ calc_ptr[1]) && (load_ptr[0] == calc_ptr[0]);

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_b_ready <= 1'b0;
            last_d    <= 1'b0;
            load_ptr  <= 2'd0;
            calc_ptr  <= 2'd0;
            row_cnt   <= '0;
        end else begin
            last_d <= accept && i_b_slice.last;
            // hold ready low until the load pointer has moved
            if (accept && i_b_slice.last)
                o_b_ready <= 1'b0;
            else
                o_b_ready <= !bank_full && !last_d;
            if (last_d)
                load_ptr <= load_ptr + 2'd1;
            if (i_tile_done)
                calc_ptr <= calc_ptr + 2'd1;
            if (accept)
                row_cnt <= i_b_slice.last ? '0 : row_cnt + 1'b1;
        end
    end

    assign o_w_row               = i_b_slice.data;
    assign o_grid_ctrl.load_bank = load_ptr[0];
    assign o_grid_ctrl.calc_bank = calc_ptr[0];
    assign o_grid_ctrl.row_wr    = accept ? (ARRAY_N'(1) << row_cnt) : '0;
    assign o_w_avail             = !bank_empty;

    // ready is registered, so full must already have blocked it
    a_no_accept_full: assert property (@(posedge s_clk) disable iff (s_rst)
        accept |-> !bank_full);

endmodule
